// ==== hdl/priv_pkg.sv ====
`default_nettype none

package priv_pkg;

    typedef logic [31:0] word_t;
    typedef logic [13:0] csr_addr_t;
    typedef logic [6:0]  exp_t;

    localparam csr_addr_t CSR_CRMD  = 14'h00;
    localparam csr_addr_t CSR_PRMD  = 14'h01;
    localparam csr_addr_t CSR_ECFG  = 14'h04;
    localparam csr_addr_t CSR_ESTAT = 14'h05;
    localparam csr_addr_t CSR_ERA   = 14'h06;
    localparam csr_addr_t CSR_SAVE0 = 14'h30;
    localparam csr_addr_t CSR_SAVE1 = 14'h31;
    localparam csr_addr_t CSR_SAVE2 = 14'h32;
    localparam csr_addr_t CSR_SAVE3 = 14'h33;
    localparam csr_addr_t CSR_TCFG  = 14'h41;
    localparam csr_addr_t CSR_TVAL  = 14'h42;
    localparam csr_addr_t CSR_TICLR = 14'h44;

    localparam int PLV_W         = 2;    // plv / pplv at [1:0]
    localparam int IE_BIT        = 2;    // ie / pie
    localparam int ESTAT_TI_BIT  = 11;   // same bit in ecfg.lie
    localparam int TCFG_EN_BIT   = 0;
    localparam int TCFG_PER_BIT  = 1;
    localparam int TCFG_INIT_LSB = 2;

    typedef enum logic [1:0] {
        CACHE_L1I = 2'd0,
        CACHE_L1D = 2'd1,
        CACHE_L2  = 2'd2
    } cache_sel_t;

    // codes 2 and 3 both target l2
    function automatic cache_sel_t cache_sel_of(logic [1:0] code);
        case (code)
            2'd0:    return CACHE_L1I;
            2'd1:    return CACHE_L1D;
            default: return CACHE_L2;
        endcase
    endfunction

endpackage

`default_nettype wire

// ==== hdl/csr_if.sv ====
`default_nettype none

interface csr_if import priv_pkg::*; ();

    logic      query_en;
    csr_addr_t addr;
    word_t     wen;       // per-bit write mask
    word_t     wdata;
    logic      restore;   // ertn state restore
    word_t     rdata;     // old value, combinational from addr
    word_t     era;
    logic      irq_pending;

    modport ctrl (
        output query_en, addr, wen, wdata, restore,
        input  rdata, era, irq_pending
    );

    modport csr (
        input  query_en, addr, wen, wdata, restore,
        output rdata, era, irq_pending
    );

endinterface

`default_nettype wire

// ==== hdl/priv_ctrl_fsm.sv ====
`default_nettype none

module priv_ctrl_fsm import priv_pkg::*; (
    input  wire        clk,
    input  wire        rstn,
    input  wire        en_in,
    input  wire        is_csr,
    input  wire        is_ertn,
    input  wire        is_idle,
    input  wire        is_cache,
    input  wire word_t inst,
    input  wire word_t pc_next,
    input  wire word_t sr0,      // rj
    input  wire word_t sr1,      // rk
    input  wire word_t imm,
    input  wire [4:0]  addr_in,
    output logic       en_out,
    output logic       flush,
    output logic       stall,
    output word_t      pc_target,
    output word_t      result,
    output word_t      cacop_addr,
    output logic [4:0] addr_out,
    output exp_t       exp_out,
    output logic [1:0] cacop_code,
    output logic       l1i_en,
    output logic       l1d_en,
    output logic       l2_en,
    input  wire        l1i_ready,
    input  wire        l1d_ready,
    input  wire        l2_ready,
    input  wire        l1i_complete,
    input  wire        l1d_complete,
    input  wire        l2_complete,
    input  wire exp_t  iexp_in,
    input  wire exp_t  dexp_in,
    csr_if.ctrl        csr
);

    localparam int S_INIT      = 0;
    localparam int S_CSR       = 1;
    localparam int S_CSR_DONE  = 2;
    localparam int S_ERTN      = 3;
    localparam int S_ERTN_DONE = 4;
    localparam int S_IDLE      = 5;
    localparam int S_IDLE_DONE = 6;
    localparam int S_CREQ      = 7;
    localparam int S_CWAIT     = 8;
    localparam int S_CDONE     = 9;
    localparam int NS          = 10;

    logic [NS-1:0] state;
    logic [NS-1:0] state_d;
    logic          accept;
    logic          start;
    logic          done_d;
    cache_sel_t    sel;
    cache_sel_t    sel_d;
    logic          sel_ready;
    logic          sel_complete;
    exp_t          sel_exp;
    exp_t          exp_acc;
    exp_t          exp_next;

    assign accept   = en_in && (is_csr || is_ertn || is_idle || is_cache);
    assign start    = accept && !stall;   // new instructions only while not stalled
    assign sel_d    = cache_sel_of(inst[1:0]);
    assign exp_next = exp_acc | sel_exp;
    assign done_d   = state_d[S_CSR_DONE] | state_d[S_ERTN_DONE]
                    | state_d[S_IDLE_DONE] | state_d[S_CDONE];

    // handshake of the cache picked at start
    always_comb begin
        case (sel)
            CACHE_L1I: begin
                sel_ready    = l1i_ready;
                sel_complete = l1i_complete;
                sel_exp      = iexp_in;
            end
            CACHE_L1D: begin
                sel_ready    = l1d_ready;
                sel_complete = l1d_complete;
                sel_exp      = dexp_in;
            end
            default: begin
                sel_ready    = l2_ready;
                sel_complete = l2_complete;
                sel_exp      = '0;   // l2 reports nothing
            end
        endcase
    end

    always_comb begin
        state_d = '0;
        case (1'b1)
            state[S_CSR]:   state_d[S_CSR_DONE]  = 1'b1;
            state[S_ERTN]:  state_d[S_ERTN_DONE] = 1'b1;
            state[S_IDLE]:  state_d[csr.irq_pending ? S_IDLE_DONE : S_IDLE] = 1'b1;
            state[S_CREQ]:  state_d[sel_ready ? S_CWAIT : S_CREQ] = 1'b1;
            state[S_CWAIT]: state_d[sel_complete ? S_CDONE : S_CWAIT] = 1'b1;
            default: begin
                // init and all done states accept the next instruction
                if (!start) begin
                    state_d[S_INIT] = 1'b1;
                end else if (is_csr) begin
                    state_d[S_CSR] = 1'b1;
                end else if (is_ertn) begin
                    state_d[S_ERTN] = 1'b1;
                end else if (is_idle) begin
                    state_d[S_IDLE] = 1'b1;
                end else begin
                    state_d[S_CREQ] = 1'b1;
                end
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state         <= '0;
            state[S_INIT] <= 1'b1;
            en_out        <= 1'b0;
            flush         <= 1'b0;
            stall         <= 1'b0;
            l1i_en        <= 1'b0;
            l1d_en        <= 1'b0;
            l2_en         <= 1'b0;
            csr.query_en  <= 1'b0;
            csr.restore   <= 1'b0;
            exp_out       <= '0;
        end else begin
            state        <= state_d;
            en_out       <= done_d;
            flush        <= done_d;
            csr.query_en <= state_d[S_CSR];    // single query cycle
            csr.restore  <= state_d[S_ERTN];
            exp_out      <= state_d[S_CDONE] ? exp_next : '0;
            if (start) begin
                stall <= 1'b1;
            end else if (done_d) begin
                stall <= 1'b0;
            end
            if (start && state_d[S_CREQ]) begin
                l1i_en <= sel_d == CACHE_L1I;
                l1d_en <= sel_d == CACHE_L1D;
                l2_en  <= sel_d == CACHE_L2;
            end else if (state_d[S_CWAIT]) begin
                l1i_en <= 1'b0;
                l1d_en <= 1'b0;
                l2_en  <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            pc_target  <= state_d[S_ERTN] ? csr.era : pc_next;
            addr_out   <= addr_in;
            csr.addr   <= imm[13:0];
            csr.wen    <= (inst[9:5] == 5'd1) ? '1 : sr0;   // csrwr writes all bits
            csr.wdata  <= sr1;
            cacop_addr <= sr0 + imm;
            cacop_code <= inst[4:3];
            sel        <= sel_d;
            exp_acc    <= '0;
        end else if (state[S_CWAIT]) begin
            exp_acc <= exp_next;
        end
        if (state_d[S_CSR_DONE]) begin
            result <= csr.rdata;
        end
    end

    a_state_onehot: assert property (@(posedge clk) disable iff (!rstn) $onehot(state));

    // every done pulse closes a stalled stretch
    a_done_after_stall: assert property (@(posedge clk) disable iff (!rstn)
        en_out |-> !stall && $past(stall));

endmodule

`default_nettype wire

// ==== hdl/csr_file.sv ====
`default_nettype none

module csr_file import priv_pkg::*; #(
    parameter int TIMER_WIDTH = 32
) (
    input  wire                   clk,
    input  wire                   rstn,
    csr_if.csr                    csr,
    output logic                  tcfg_wr,
    output word_t                 tcfg_val,
    input  wire [TIMER_WIDTH-1:0] tval,
    input  wire                   timer_irq
);

    // software-writable bits per register
    localparam word_t CRMD_MASK  = 32'h0000_01ff;
    localparam word_t PRMD_MASK  = 32'h0000_0007;
    localparam word_t ECFG_MASK  = 32'h0000_1bff;
    localparam word_t ESTAT_MASK = 32'h0000_0003;   // sw interrupts only
    localparam word_t TCFG_MASK  = word_t'({TIMER_WIDTH{1'b1}});

    word_t crmd;
    word_t prmd;
    word_t ecfg;
    word_t estat;
    word_t era;
    word_t tcfg;
    word_t save [4];
    word_t wr_val;
    logic  ticlr_clr;

    function automatic word_t merge(word_t old, word_t nv, word_t m);
        return (old & ~m) | (nv & m);
    endfunction

    always_comb begin
        case (csr.addr)
            CSR_CRMD:  csr.rdata = crmd;
            CSR_PRMD:  csr.rdata = prmd;
            CSR_ECFG:  csr.rdata = ecfg;
            CSR_ESTAT: csr.rdata = estat;
            CSR_ERA:   csr.rdata = era;
            CSR_SAVE0, CSR_SAVE1, CSR_SAVE2, CSR_SAVE3: begin
                csr.rdata = save[csr.addr[1:0]];
            end
            CSR_TCFG:  csr.rdata = tcfg;
            CSR_TVAL:  csr.rdata = word_t'(tval);
            default:   csr.rdata = '0;   // ticlr reads as zero
        endcase
    end

    assign wr_val          = (csr.rdata & ~csr.wen) | (csr.wdata & csr.wen);
    assign ticlr_clr       = csr.query_en && csr.addr == CSR_TICLR && wr_val[0];
    assign tcfg_val        = tcfg;
    assign csr.era         = era;
    assign csr.irq_pending = estat[ESTAT_TI_BIT] && ecfg[ESTAT_TI_BIT];

    always_ff @(posedge clk) begin
        if (!rstn) begin
            crmd    <= '0;
            prmd    <= '0;
            ecfg    <= '0;
            estat   <= '0;
            era     <= '0;
            tcfg    <= '0;
            tcfg_wr <= 1'b0;
            for (int i = 0; i < 4; i++) begin
                save[i] <= '0;
            end
        end else begin
            tcfg_wr <= 1'b0;
            if (csr.query_en) begin
                case (csr.addr)
                    CSR_CRMD:  crmd  <= merge(crmd, wr_val, CRMD_MASK);
                    CSR_PRMD:  prmd  <= merge(prmd, wr_val, PRMD_MASK);
                    CSR_ECFG:  ecfg  <= merge(ecfg, wr_val, ECFG_MASK);
                    CSR_ESTAT: estat <= merge(estat, wr_val, ESTAT_MASK);
                    CSR_ERA:   era   <= wr_val;
                    CSR_SAVE0, CSR_SAVE1, CSR_SAVE2, CSR_SAVE3: begin
                        save[csr.addr[1:0]] <= wr_val;
                    end
                    CSR_TCFG: begin
                        tcfg    <= merge(tcfg, wr_val, TCFG_MASK);
                        tcfg_wr <= 1'b1;   // timer reloads next cycle
                    end
                    default: ;
                endcase
            end
            if (csr.restore) begin
                crmd[PLV_W-1:0] <= prmd[PLV_W-1:0];
                crmd[IE_BIT]    <= prmd[IE_BIT];
            end
            // a fresh tick wins over a clear
            if (timer_irq) begin
                estat[ESTAT_TI_BIT] <= 1'b1;
            end else if (ticlr_clr) begin
                estat[ESTAT_TI_BIT] <= 1'b0;
            end
        end
    end

    a_restore_not_query: assert property (@(posedge clk) disable iff (!rstn)
        !(csr.restore && csr.query_en));

endmodule

`default_nettype wire

// ==== hdl/stable_timer.sv ====
`default_nettype none

module stable_timer import priv_pkg::*; #(
    parameter int TIMER_WIDTH = 32
) (
    input  wire                    clk,
    input  wire                    rstn,
    input  wire                    tcfg_wr,
    input  wire word_t             tcfg_val,
    output logic [TIMER_WIDTH-1:0] tval,
    output logic                   timer_irq
);

    logic                   en;
    logic                   periodic;
    logic [TIMER_WIDTH-1:0] init_val;
    logic [TIMER_WIDTH-1:0] load_val;

    // low bits of the count forced to zero
    assign load_val = {tcfg_val[TIMER_WIDTH-1:TCFG_INIT_LSB], {TCFG_INIT_LSB{1'b0}}};

    always_ff @(posedge clk) begin
        if (!rstn) begin
            en        <= 1'b0;
            periodic  <= 1'b0;
            tval      <= '0;
            timer_irq <= 1'b0;
        end else begin
            timer_irq <= 1'b0;
            if (tcfg_wr) begin
                en       <= tcfg_val[TCFG_EN_BIT];
                periodic <= tcfg_val[TCFG_PER_BIT];
                tval     <= load_val;
            end else if (en) begin
                if (tval != '0) begin
                    tval      <= tval - TIMER_WIDTH'(1);
                    timer_irq <= tval == TIMER_WIDTH'(1);   // 1 -> 0 step
                end else if (periodic) begin
                    tval <= init_val;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (tcfg_wr) begin
            init_val <= load_val;
        end
    end

    a_irq_only_enabled: assert property (@(posedge clk) disable iff (!rstn)
        timer_irq |-> en && $past(en));

endmodule

`default_nettype wire

// ==== hdl/priv_unit_top.sv ====
`default_nettype none

module priv_unit_top import priv_pkg::*; #(
    parameter int TIMER_WIDTH = 32
) (
    input  wire        clk,
    input  wire        rstn,
    input  wire        en_in,
    input  wire        is_csr,
    input  wire        is_ertn,
    input  wire        is_idle,
    input  wire        is_cache,
    input  wire word_t inst,
    input  wire word_t pc_next,
    input  wire word_t sr0,
    input  wire word_t sr1,
    input  wire word_t imm,
    input  wire [4:0]  addr_in,
    output wire        en_out,
    output wire        flush,
    output wire        stall,
    output wire word_t pc_target,
    output wire word_t result,
    output wire word_t cacop_addr,
    output wire [4:0]  addr_out,
    output wire exp_t  exp_out,
    output wire [1:0]  cacop_code,
    output wire        l1i_en,
    output wire        l1d_en,
    output wire        l2_en,
    input  wire        l1i_ready,
    input  wire        l1d_ready,
    input  wire        l2_ready,
    input  wire        l1i_complete,
    input  wire        l1d_complete,
    input  wire        l2_complete,
    input  wire exp_t  iexp_in,
    input  wire exp_t  dexp_in
);

    csr_if                  csr_bus ();
    logic                   tcfg_wr;
    word_t                  tcfg_val;
    logic [TIMER_WIDTH-1:0] tval;
    logic                   timer_irq;

    priv_ctrl_fsm u_priv_ctrl_fsm (
        .*,
        .csr (csr_bus.ctrl)
    );

    csr_file #(
        .TIMER_WIDTH (TIMER_WIDTH)
    ) u_csr_file (
        .*,
        .csr (csr_bus.csr)
    );

    // timer link is plain wires
    stable_timer #(
        .TIMER_WIDTH (TIMER_WIDTH)
    ) u_stable_timer (
        .*
    );

endmodule

`default_nettype wire

// ==== test/tb_priv_unit.sv ====
`default_nettype none

module tb_priv_unit import priv_pkg::*; ();

    localparam int MAX_CYCLES = 20000;   // 200 csr ops, 40 cacops of up to ~20 cycles, idle ~70
    localparam int N_CSR_OPS  = 200;
    localparam int N_CACHE_OPS = 40;
    localparam int K_CSR      = 0;
    localparam int K_ERTN     = 1;
    localparam int K_IDLE     = 2;
    localparam int K_CACHE    = 3;
    localparam word_t TIMER_INIT = 32'h40;   // initval sits above the en and periodic bits
    localparam csr_addr_t RW_CSRS [6] = '{CSR_SAVE0, CSR_SAVE1, CSR_SAVE2, CSR_SAVE3,
                                          CSR_ERA, CSR_PRMD};

    logic        clk = 1'b0;
    logic        rstn;
    logic        en_in;
    logic        is_csr;
    logic        is_ertn;
    logic        is_idle;
    logic        is_cache;
    word_t       inst;
    word_t       pc_next;
    word_t       sr0;
    word_t       sr1;
    word_t       imm;
    logic [4:0]  addr_in;
    logic [2:0]  c_ready;      // l1i, l1d, l2
    logic [2:0]  c_complete;
    exp_t        c_exp [3];
    wire         en_out;
    wire         flush;
    wire         stall;
    wire word_t  pc_target;
    wire word_t  result;
    wire word_t  cacop_addr;
    wire [4:0]   addr_out;
    wire exp_t   exp_out;
    wire [1:0]   cacop_code;
    wire         l1i_en;
    wire         l1d_en;
    wire         l2_en;

    word_t       shadow [csr_addr_t];
    int          q_kind [$];
    word_t       q_val [$];
    word_t       q_mask [$];
    exp_t        model_exp;
    logic [31:0] rng = 32'd59893;
    int          errors;
    int          checks;
    int          cycles;
    int          cmp_kind;
    word_t       cmp_val;
    word_t       cmp_mask;

    priv_unit_top #(
        .TIMER_WIDTH (32)
    ) u_priv_unit_top (
        .*,
        .l1i_ready    (c_ready[0]),
        .l1d_ready    (c_ready[1]),
        .l2_ready     (c_ready[2]),
        .l1i_complete (c_complete[0]),
        .l1d_complete (c_complete[1]),
        .l2_complete  (c_complete[2]),
        .iexp_in      (c_exp[0]),
        .dexp_in      (c_exp[1])
    );

    always #5 clk = ~clk;

    function automatic word_t xorshift();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    // architecturally writable bits
    function automatic word_t writable_bits(csr_addr_t a);
        case (a)
            CSR_CRMD: return 32'h0000_01ff;
            CSR_PRMD: return 32'h0000_0007;
            CSR_ECFG: return 32'h0000_1bff;
            default:  return 32'hffff_ffff;
        endcase
    endfunction

    // csrrd rj=0, csrwr rj=1, csrxchg masks with rj
    function automatic word_t write_mask(logic [4:0] rj, word_t mask_reg);
        if (rj == 5'd0) begin
            return '0;
        end
        return (rj == 5'd1) ? '1 : mask_reg;
    endfunction

    // returns the old value and applies the write to the shadow copy
    function automatic word_t csr_ref(csr_addr_t a, word_t m, word_t wd);
        word_t old;
        word_t wm;
        old = shadow[a];
        wm  = m & writable_bits(a);
        if (a != CSR_ESTAT && a != CSR_TVAL && a != CSR_TICLR) begin
            shadow[a] = (old & ~wm) | (wd & wm);
        end
        return old;
    endfunction

    function automatic word_t ertn_ref();
        shadow[CSR_CRMD][1:0] = shadow[CSR_PRMD][1:0];   // pplv -> plv
        shadow[CSR_CRMD][2]   = shadow[CSR_PRMD][2];     // pie -> ie
        return shadow[CSR_ERA];
    endfunction

    function automatic logic cache_en(logic [1:0] c);
        case (c)
            2'd0:    return l1i_en;
            2'd1:    return l1d_en;
            default: return l2_en;
        endcase
    endfunction

    task automatic check(string name, word_t got, word_t want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("Error at %0t: %s is %h, expected %h", $time, name, got, want);
        end
    endtask

    task automatic issue(int kind, word_t ins, word_t s0, word_t s1, word_t im);
        int lat;
        is_csr   = kind == K_CSR;
        is_ertn  = kind == K_ERTN;
        is_idle  = kind == K_IDLE;
        is_cache = kind == K_CACHE;
        inst     = ins;
        sr0      = s0;
        sr1      = s1;
        imm      = im;
        pc_next  = xorshift();
        addr_in  = 5'(xorshift());
        en_in    = 1'b1;
        @(negedge clk);
        en_in    = 1'b0;
        {is_csr, is_ertn, is_idle, is_cache} = 4'b0;
        check("stall", word_t'(stall), 32'd1);
        check("en_out", word_t'(en_out), 32'd0);
        check("addr_out", word_t'(addr_out), word_t'(addr_in));
        if (kind != K_ERTN) begin
            check("pc_target", pc_target, pc_next);
        end
        if (kind == K_CACHE) begin
            check("cacop_addr", cacop_addr, s0 + im);
            check("cacop_code", word_t'(cacop_code), word_t'(ins[4:3]));
            check("l1i_en", word_t'(l1i_en), word_t'(ins[1:0] == 2'd0));
            check("l1d_en", word_t'(l1d_en), word_t'(ins[1:0] == 2'd1));
            check("l2_en", word_t'(l2_en), word_t'(ins[1]));   // codes 2 and 3
        end
        lat = 1;
        @(negedge clk);
        while (!en_out) begin
            @(negedge clk);
            lat++;
        end
        if (kind == K_CSR || kind == K_ERTN) begin
            check("en_out latency", word_t'(lat), 32'd1);
        end
    endtask

    task automatic csr_op(csr_addr_t a, logic [4:0] rj, word_t s0, word_t s1);
        q_kind.push_back(K_CSR);
        q_val.push_back(csr_ref(a, write_mask(rj, s0), s1));
        // volatile registers are checked by the caller
        q_mask.push_back((a == CSR_ESTAT || a == CSR_TVAL || a == CSR_TICLR) ? '0 : '1);
        issue(K_CSR, word_t'(rj) << 5, s0, s1, word_t'(a));
    endtask

    task automatic cache_model(logic [1:0] c);
        int   d;
        exp_t acc;
        forever begin
            @(negedge clk);
            if (rstn && cache_en(c)) begin
                d = int'(xorshift() & 32'd7);
                repeat (d) @(negedge clk);
                c_ready[c] = 1'b1;
                @(negedge clk);
                c_ready[c] = 1'b0;
                acc = '0;
                d = int'(xorshift() & 32'd7);
                for (int k = 0; k <= d; k++) begin
                    if (k > 0) begin
                        @(negedge clk);
                    end
                    if (c != 2'd2) begin
                        c_exp[c] = exp_t'(xorshift());   // l2 has no exception port
                    end
                    acc = acc | c_exp[c];
                    c_complete[c] = k == d;
                end
                model_exp = acc;
                @(negedge clk);
                c_complete[c] = 1'b0;
                c_exp[c] = '0;
                check("en_out after complete", word_t'(en_out), 32'd1);
            end else if (c != 2'd2) begin
                c_exp[c] = exp_t'(xorshift());   // junk on an idle port
            end
        end
    endtask

    initial cache_model(2'd0);
    initial cache_model(2'd1);
    initial cache_model(2'd2);

    // one queue entry per instruction, popped at its done pulse
    always @(negedge clk) begin
        if (rstn && en_out) begin
            if (q_kind.size() == 0) begin
                errors++;
                $display("en_out pulsed at %0t with no instruction outstanding", $time);
            end else begin
                cmp_kind = q_kind.pop_front();
                cmp_val  = q_val.pop_front();
                cmp_mask = q_mask.pop_front();
                check("flush", word_t'(flush), 32'd1);
                check("stall at done", word_t'(stall), 32'd0);
                if (cmp_kind == K_CSR) begin
                    check("result", result & cmp_mask, cmp_val & cmp_mask);
                end else if (cmp_kind == K_ERTN) begin
                    check("pc_target", pc_target, cmp_val);
                end else if (cmp_kind == K_CACHE) begin
                    check("exp_out", word_t'(exp_out), word_t'(model_exp));
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: run stopped after %0d cycles", cycles);
            $display("checks %0d, errors %0d", checks, errors);
            $display("Testbench failed");
            $finish;
        end
    end

    initial begin
        csr_addr_t  a;
        int         op;
        logic [4:0] rj;
        rstn     = 1'b0;
        en_in    = 1'b0;
        {is_csr, is_ertn, is_idle, is_cache} = 4'b0;
        inst     = '0;
        pc_next  = '0;
        sr0      = '0;
        sr1      = '0;
        imm      = '0;
        addr_in  = '0;
        c_ready    = '0;
        c_complete = '0;
        c_exp      = '{default: '0};
        model_exp  = '0;
        for (int i = 0; i < 128; i++) begin
            shadow[csr_addr_t'(i)] = '0;
        end
        repeat (16) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;

        check("en_out after reset", word_t'(en_out), 32'd0);
        check("stall after reset", word_t'(stall), 32'd0);
        check("flush after reset", word_t'(flush), 32'd0);
        check("cache enables after reset", word_t'({l1i_en, l1d_en, l2_en}), 32'd0);
        csr_op(CSR_CRMD, 5'd0, '0, '0);

        for (int i = 0; i < N_CSR_OPS; i++) begin
            a  = RW_CSRS[int'(xorshift() % 32'd6)];
            op = int'(xorshift() % 32'd3);
            rj = (op == 0) ? 5'd0 : (op == 1) ? 5'd1 : 5'(32'd2 + xorshift() % 32'd30);
            csr_op(a, rj, (op == 0) ? '0 : xorshift(), xorshift());
        end

        repeat (4) begin
            csr_op(CSR_ERA, 5'd1, '0, xorshift());
            csr_op(CSR_PRMD, 5'd1, '0, xorshift());
            q_kind.push_back(K_ERTN);
            q_val.push_back(ertn_ref());
            q_mask.push_back('1);
            issue(K_ERTN, '0, '0, '0, '0);
            csr_op(CSR_CRMD, 5'd0, '0, '0);
        end

        repeat (N_CACHE_OPS) begin
            q_kind.push_back(K_CACHE);
            q_val.push_back('0);
            q_mask.push_back('0);
            issue(K_CACHE, xorshift() & 32'h0000_001b, xorshift(), xorshift(), xorshift());
        end

        csr_op(CSR_ECFG, 5'd1, '0, word_t'(1) << ESTAT_TI_BIT);
        csr_op(CSR_TCFG, 5'd1, '0, TIMER_INIT | 32'd1);   // enabled, one shot
        q_kind.push_back(K_IDLE);
        q_val.push_back('0);
        q_mask.push_back('0);
        issue(K_IDLE, '0, '0, '0, '0);
        csr_op(CSR_ESTAT, 5'd0, '0, '0);
        check("estat.ti after idle", word_t'(result[ESTAT_TI_BIT]), 32'd1);
        csr_op(CSR_TVAL, 5'd0, '0, '0);
        check("tval within initval", word_t'(result <= TIMER_INIT), 32'd1);
        csr_op(CSR_TICLR, 5'd1, '0, 32'd1);
        csr_op(CSR_ESTAT, 5'd0, '0, '0);
        check("estat.ti after ticlr", word_t'(result[ESTAT_TI_BIT]), 32'd0);

        repeat (4) @(negedge clk);
        if (q_kind.size() != 0) begin
            errors++;
            $display("%0d instructions never signalled completion", q_kind.size());
        end
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
hdl/priv_pkg.sv
hdl/csr_if.sv
hdl/priv_ctrl_fsm.sv
hdl/csr_file.sv
hdl/stable_timer.sv
hdl/priv_unit_top.sv
test/tb_priv_unit.sv

// ==== run.sh ====
#!/bin/sh
# build with verilator, run, then look for the pass line in the log
rm -f sim.log &&
verilator --binary --timing --assert -f sources.f --top-module tb_priv_unit -o tb_priv_unit &&
./obj_dir/tb_priv_unit > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qs "Testbench passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
